//--- verilog/cpu_types_pkg.sv
// word, register, opcode and instruction types shared by every pipeline block
`default_nettype none

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcodes, MIPS encoding
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // funct field of rtype words
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL
  } aluop_t;

  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_view_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm16;
  } i_view_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_view_t;

  // one fetched word, read as whichever format the opcode implies
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    j_view_t j_view;
  } instr_u;

  localparam word_t    PC_INIT  = 32'h0000_0000;
  localparam regbits_t LINK_REG = 5'd31;

endpackage

`default_nettype wire

//--- verilog/data_path_muxs_pkg.sv
// select codes driving the datapath muxes, shared by decode, hazard and forwarding logic
`default_nettype none

package data_path_muxs_pkg;

  // alu port b source
  localparam logic SEL_REG_DATA = 1'b0;
  localparam logic SEL_IMM16    = 1'b1;

  // destination register
  localparam logic [1:0] SEL_RD              = 2'd0;
  localparam logic [1:0] SEL_RT              = 2'd1;
  localparam logic [1:0] SEL_RETURN_REGISTER = 2'd2;

  // writeback data
  localparam logic [1:0] SEL_RESULT = 2'd0;
  localparam logic [1:0] SEL_DLOAD  = 2'd1;
  localparam logic [1:0] SEL_NPC    = 2'd2;

  // immediate extension
  localparam logic [1:0] EXT_ZERO  = 2'd0;
  localparam logic [1:0] EXT_SIGN  = 2'd1;
  localparam logic [1:0] EXT_UPPER = 2'd2;

  // next pc
  localparam logic [1:0] SEL_LOAD_NXT_INSTR = 2'd0;
  localparam logic [1:0] SEL_LOAD_JMP_ADDR  = 2'd1;
  localparam logic [1:0] SEL_LOAD_JR_ADDR   = 2'd2;
  localparam logic [1:0] SEL_LOAD_BR_ADDR   = 2'd3;

  // forwarding source for an operand
  localparam logic [1:0] FWD_NONE = 2'd0;
  localparam logic [1:0] FWD_MEM  = 2'd1;
  localparam logic [1:0] FWD_WB   = 2'd2;

endpackage

`default_nettype wire

//--- verilog/control_unit.sv
// decode stage control, turns opcode and funct into the per-stage control signals
`default_nettype none

module control_unit
  import cpu_types_pkg::*;
  import data_path_muxs_pkg::*;
(
  input  opcode_t    opcode,
  input  funct_t     funct,
  output aluop_t     alu_op,
  output logic       alu_src,
  output logic [1:0] reg_dest,
  output logic [1:0] mem_to_reg,
  output logic [1:0] extend,
  output logic       wen,
  output logic       dren,
  output logic       dwen,
  output logic       is_branch_ne,
  output logic       is_branch_eq,
  output logic       is_jump,
  output logic       is_jal,
  output logic       is_jr,
  output logic       is_halt
);

  always_comb begin
    // defaults give a no-op
    alu_op       = ALU_ADD;
    alu_src      = SEL_REG_DATA;
    reg_dest     = SEL_RD;
    mem_to_reg   = SEL_RESULT;
    extend       = EXT_SIGN;
    wen          = 1'b0;
    dren         = 1'b0;
    dwen         = 1'b0;
    is_branch_ne = 1'b0;
    is_branch_eq = 1'b0;
    is_jump      = 1'b0;
    is_jal       = 1'b0;
    is_jr        = 1'b0;
    is_halt      = 1'b0;

    case (opcode)
      RTYPE: begin
        wen = 1'b1;
        case (funct)
          ADDU: alu_op = ALU_ADD;
          SUBU: alu_op = ALU_SUB;
          AND:  alu_op = ALU_AND;
          OR:   alu_op = ALU_OR;
          SLT:  alu_op = ALU_SLT;
          SLL:  alu_op = ALU_SLL;
          JR: begin
            wen   = 1'b0;
            is_jr = 1'b1;
          end
          default: wen = 1'b0;
        endcase
      end
      ADDIU: begin
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        wen      = 1'b1;
      end
      ORI: begin
        alu_op   = ALU_OR;
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        extend   = EXT_ZERO;
        wen      = 1'b1;
      end
      // rs is zero in a lui word, so the add just passes the upper immediate
      LUI: begin
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        extend   = EXT_UPPER;
        wen      = 1'b1;
      end
      LW: begin
        alu_src    = SEL_IMM16;
        reg_dest   = SEL_RT;
        mem_to_reg = SEL_DLOAD;
        dren       = 1'b1;
        wen        = 1'b1;
      end
      SW: begin
        alu_src = SEL_IMM16;
        dwen    = 1'b1;
      end
      BEQ: begin
        alu_op       = ALU_SUB;
        is_branch_eq = 1'b1;
      end
      BNE: begin
        alu_op       = ALU_SUB;
        is_branch_ne = 1'b1;
      end
      J:    is_jump = 1'b1;
      JAL: begin
        is_jal     = 1'b1;
        reg_dest   = SEL_RETURN_REGISTER;
        mem_to_reg = SEL_NPC;
        wen        = 1'b1;
      end
      HALT:    is_halt = 1'b1;
      default: wen = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
// execute stage arithmetic and logic, result plus zero flag for branch compare
`default_nettype none

module alu
  import cpu_types_pkg::*;
(
  input  word_t      port_a,
  input  word_t      port_b,
  input  logic [4:0] shamt,
  input  aluop_t     alu_op,
  output word_t      result,
  output logic       zero
);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      // signed compare
      ALU_SLT: result = {31'd0, $signed(port_a) < $signed(port_b)};
      // sll shifts rt, which arrives on port b
      ALU_SLL: result = port_b << shamt;
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- verilog/register_file.sv
// 32 x 32 general purpose registers, two read ports and one write port
`default_nettype none

module register_file
  import cpu_types_pkg::*;
(
  input  logic     CLK,
  input  logic     reset,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-through so decode sees the value being written back this cycle
  assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
// pipeline control, stage enables, flushes and pc source from hits and hazards
`default_nettype none

module hazard_unit
  import cpu_types_pkg::*;
  import data_path_muxs_pkg::*;
(
  input  logic       ihit,
  input  logic       dhit,
  input  logic       dren_mem,
  input  logic       dwen_mem,
  input  logic       load_ex,
  input  regbits_t   rt_ex,
  input  regbits_t   reg_wr_ex,
  input  logic       wen_ex,
  input  regbits_t   reg_wr_mem,
  input  logic       wen_mem,
  input  regbits_t   rs_id,
  input  regbits_t   rt_id,
  input  logic       is_jump,
  input  logic       is_jal,
  input  logic       is_jr,
  input  logic       is_branch_eq_mem,
  input  logic       is_branch_ne_mem,
  input  logic       zero_mem,
  input  logic       halt,
  output logic [1:0] pc_src,
  output logic       enable_pc,
  output logic       enable_if_id,
  output logic       enable_id_ex,
  output logic       enable_ex_mem,
  output logic       enable_mem_wb,
  output logic       flush_if_id,
  output logic       flush_id_ex,
  output logic       flush_ex_mem
);

  logic freeze;
  logic branch_taken;
  logic load_use;
  logic jr_wait;

  assign freeze       = ~ihit | ((dren_mem | dwen_mem) & ~dhit) | halt;
  assign branch_taken = (is_branch_eq_mem & zero_mem) | (is_branch_ne_mem & ~zero_mem);
  assign load_use     = load_ex && rt_ex != '0 && (rt_ex == rs_id || rt_ex == rt_id);

  // jr reads rs in decode, wait for ex and mem writers to retire
  assign jr_wait = is_jr && rs_id != '0 &&
                   ((wen_ex && reg_wr_ex == rs_id) || (wen_mem && reg_wr_mem == rs_id));

  always_comb begin
    pc_src = SEL_LOAD_NXT_INSTR;
    {enable_pc, enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb} = '1;
    {flush_if_id, flush_id_ex, flush_ex_mem} = '0;

    if (freeze) begin
      {enable_pc, enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb} = '0;
    end else if (branch_taken) begin
      pc_src = SEL_LOAD_BR_ADDR;
      {flush_if_id, flush_id_ex, flush_ex_mem} = '1;
    end else if (load_use || jr_wait) begin
      // hold fetch and decode, bubble into execute
      enable_pc    = 1'b0;
      enable_if_id = 1'b0;
      flush_id_ex  = 1'b1;
    end else if (is_jump || is_jal || is_jr) begin
      pc_src      = is_jr ? SEL_LOAD_JR_ADDR : SEL_LOAD_JMP_ADDR;
      flush_if_id = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/forward_unit.sv
// picks the forwarding source for alu port a, alu port b and the store data
`default_nettype none

module forward_unit
  import cpu_types_pkg::*;
  import data_path_muxs_pkg::*;
(
  input  regbits_t   rs,
  input  regbits_t   rt,
  input  regbits_t   reg_wr_mem,
  input  regbits_t   reg_wr_wb,
  input  logic       wen_mem,
  input  logic       wen_wb,
  output logic [1:0] porta_sel,
  output logic [1:0] portb_sel,
  output logic [1:0] store_sel
);

  // newest writer wins, register 0 is never forwarded
  function automatic logic [1:0] fwd_src(
    input regbits_t src,
    input regbits_t mem_dst,
    input logic     mem_wr,
    input regbits_t wb_dst,
    input logic     wb_wr
  );
    if (src != '0 && mem_wr && mem_dst == src) begin
      return FWD_MEM;
    end else if (src != '0 && wb_wr && wb_dst == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign porta_sel = fwd_src(rs, reg_wr_mem, wen_mem, reg_wr_wb, wen_wb);
  assign portb_sel = fwd_src(rt, reg_wr_mem, wen_mem, reg_wr_wb, wen_wb);
  assign store_sel = fwd_src(rt, reg_wr_mem, wen_mem, reg_wr_wb, wen_wb);

endmodule

`default_nettype wire

//--- verilog/datapath.sv
// five-stage pipeline top level that holds pc, stage registers and control blocks and serves as the DUT
`default_nettype none

module datapath
  import cpu_types_pkg::*;
  import data_path_muxs_pkg::*;
(
  input  logic  CLK,
  input  logic  reset,
  output word_t imemaddr,
  output logic  imemren,
  input  word_t imemload,
  input  logic  ihit,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  dmemren,
  output logic  dmemwen,
  input  word_t dmemload,
  input  logic  dhit,
  output logic  halt
);

  // hazard and forwarding controls
  logic [1:0] pc_src, porta_sel, portb_sel, store_sel;
  logic       enable_pc, enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb;
  logic       flush_if_id, flush_id_ex, flush_ex_mem;

  // fetch and IF/ID
  word_t  pc, pc_plus4, next_pc;
  instr_u if_id_instr;
  word_t  if_id_npc;

  // decode
  aluop_t     alu_op;
  logic       alu_src;
  logic [1:0] reg_dest, mem_to_reg, extend;
  logic       wen, dren, dwen, is_branch_ne, is_branch_eq;
  logic       is_jump, is_jal, is_jr, is_halt;
  word_t      rdat1, rdat2, imm_ext, jump_addr;
  regbits_t   dest_id;

  // ID/EX
  aluop_t     id_ex_alu_op;
  logic       id_ex_alu_src;
  logic [1:0] id_ex_mem_to_reg;
  logic       id_ex_wen, id_ex_dren, id_ex_dwen;
  logic       id_ex_branch_eq, id_ex_branch_ne, id_ex_halt;
  regbits_t   id_ex_rs, id_ex_rt, id_ex_dest;
  logic [4:0] id_ex_shamt;
  word_t      id_ex_rdat1, id_ex_rdat2, id_ex_imm, id_ex_npc;

  // execute
  word_t port_a, rt_fwd, port_b, store_data, alu_result, ex_result, br_target;
  logic  zero;

  // EX/MEM
  logic       ex_mem_wen, ex_mem_dren, ex_mem_dwen;
  logic       ex_mem_branch_eq, ex_mem_branch_ne, ex_mem_zero, ex_mem_halt;
  logic [1:0] ex_mem_mem_to_reg;
  regbits_t   ex_mem_dest;
  word_t      ex_mem_result, ex_mem_store, ex_mem_br_target;
  logic       dmem_done;
  word_t      dload_hold;

  // MEM/WB
  logic       mem_wb_wen, mem_wb_halt;
  logic [1:0] mem_wb_mem_to_reg;
  regbits_t   mem_wb_dest;
  word_t      mem_wb_result, mem_wb_load, wdat;

  function automatic word_t fwd_mux(
    input logic [1:0] sel,
    input word_t      reg_val,
    input word_t      mem_val,
    input word_t      wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // fetch
  assign imemaddr = pc;
  assign imemren  = ~halt;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (pc_src)
      SEL_LOAD_JMP_ADDR: next_pc = jump_addr;
      SEL_LOAD_JR_ADDR:  next_pc = rdat1;
      SEL_LOAD_BR_ADDR:  next_pc = ex_mem_br_target;
      default:           next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc <= PC_INIT;
    end else if (enable_pc) begin
      pc <= next_pc;
    end
  end

  // a cleared word decodes as sll $0 which is a nop
  always_ff @(posedge CLK) begin
    if (reset || flush_if_id) begin
      if_id_instr <= '0;
    end else if (enable_if_id) begin
      if_id_instr <= instr_u'(imemload);
      if_id_npc   <= pc_plus4;
    end
  end

  // decode
  control_unit cu0 (
    .opcode(if_id_instr.r_view.opcode), .funct(if_id_instr.r_view.funct),
    .alu_op, .alu_src, .reg_dest, .mem_to_reg, .extend, .wen, .dren, .dwen,
    .is_branch_ne, .is_branch_eq, .is_jump, .is_jal, .is_jr, .is_halt
  );

  register_file rf0 (
    .CLK, .reset, .wen(mem_wb_wen), .wsel(mem_wb_dest), .wdat,
    .rsel1(if_id_instr.r_view.rs), .rsel2(if_id_instr.r_view.rt), .rdat1, .rdat2
  );

  always_comb begin
    case (extend)
      EXT_ZERO:  imm_ext = {16'h0000, if_id_instr.i_view.imm16};
      EXT_UPPER: imm_ext = {if_id_instr.i_view.imm16, 16'h0000};
      default:   imm_ext = {{16{if_id_instr.i_view.imm16[15]}}, if_id_instr.i_view.imm16};
    endcase
    case (reg_dest)
      SEL_RT:              dest_id = if_id_instr.r_view.rt;
      SEL_RETURN_REGISTER: dest_id = LINK_REG;
      default:             dest_id = if_id_instr.r_view.rd;
    endcase
  end

  assign jump_addr = {if_id_npc[31:28], if_id_instr.j_view.addr26, 2'b00};

  always_ff @(posedge CLK) begin
    if (reset || flush_id_ex) begin
      {id_ex_wen, id_ex_dren, id_ex_dwen} <= '0;
      {id_ex_branch_eq, id_ex_branch_ne, id_ex_halt} <= '0;
    end else if (enable_id_ex) begin
      {id_ex_wen, id_ex_dren, id_ex_dwen} <= {wen, dren, dwen};
      {id_ex_branch_eq, id_ex_branch_ne, id_ex_halt} <= {is_branch_eq, is_branch_ne, is_halt};
      id_ex_alu_op     <= alu_op;
      id_ex_alu_src    <= alu_src;
      id_ex_mem_to_reg <= mem_to_reg;
      id_ex_rs         <= if_id_instr.r_view.rs;
      id_ex_rt         <= if_id_instr.r_view.rt;
      id_ex_dest       <= dest_id;
      id_ex_shamt      <= if_id_instr.r_view.shamt;
      id_ex_rdat1      <= rdat1;
      id_ex_rdat2      <= rdat2;
      id_ex_imm        <= imm_ext;
      id_ex_npc        <= if_id_npc;
    end
  end

  // execute
  forward_unit fu0 (
    .rs(id_ex_rs), .rt(id_ex_rt), .reg_wr_mem(ex_mem_dest), .reg_wr_wb(mem_wb_dest),
    .wen_mem(ex_mem_wen), .wen_wb(mem_wb_wen), .porta_sel, .portb_sel, .store_sel
  );

  assign port_a     = fwd_mux(porta_sel, id_ex_rdat1, ex_mem_result, wdat);
  assign rt_fwd     = fwd_mux(portb_sel, id_ex_rdat2, ex_mem_result, wdat);
  assign store_data = fwd_mux(store_sel, id_ex_rdat2, ex_mem_result, wdat);
  assign port_b     = (id_ex_alu_src == SEL_IMM16) ? id_ex_imm : rt_fwd;

  alu alu0 (
    .port_a, .port_b, .shamt(id_ex_shamt), .alu_op(id_ex_alu_op),
    .result(alu_result), .zero
  );

  // jal carries its link value as the result so forwarding sees it
  assign ex_result = (id_ex_mem_to_reg == SEL_NPC) ? id_ex_npc : alu_result;
  assign br_target = id_ex_npc + {id_ex_imm[29:0], 2'b00};

  always_ff @(posedge CLK) begin
    if (reset || flush_ex_mem) begin
      {ex_mem_wen, ex_mem_dren, ex_mem_dwen} <= '0;
      {ex_mem_branch_eq, ex_mem_branch_ne, ex_mem_halt} <= '0;
    end else if (enable_ex_mem) begin
      {ex_mem_wen, ex_mem_dren, ex_mem_dwen} <= {id_ex_wen, id_ex_dren, id_ex_dwen};
      {ex_mem_branch_eq, ex_mem_branch_ne, ex_mem_halt} <=
        {id_ex_branch_eq, id_ex_branch_ne, id_ex_halt};
      ex_mem_zero       <= zero;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      ex_mem_dest       <= id_ex_dest;
      ex_mem_result     <= ex_result;
      ex_mem_store      <= store_data;
      ex_mem_br_target  <= br_target;
    end
  end

  // a finished memory access is not reissued while fetch still waits
  assign dmemaddr  = ex_mem_result;
  assign dmemstore = ex_mem_store;
  assign dmemren   = ex_mem_dren & ~dmem_done & ~halt;
  assign dmemwen   = ex_mem_dwen & ~dmem_done & ~halt;

  always_ff @(posedge CLK) begin
    if (reset || enable_mem_wb) begin
      dmem_done <= 1'b0;
    end else if (dhit && (dmemren || dmemwen)) begin
      dmem_done <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (dhit) begin
      dload_hold <= dmemload;
    end
  end

  hazard_unit hu0 (
    .ihit, .dhit, .dren_mem(dmemren), .dwen_mem(dmemwen),
    .load_ex(id_ex_dren), .rt_ex(id_ex_rt), .reg_wr_ex(id_ex_dest), .wen_ex(id_ex_wen),
    .reg_wr_mem(ex_mem_dest), .wen_mem(ex_mem_wen),
    .rs_id(if_id_instr.r_view.rs), .rt_id(if_id_instr.r_view.rt),
    .is_jump, .is_jal, .is_jr,
    .is_branch_eq_mem(ex_mem_branch_eq), .is_branch_ne_mem(ex_mem_branch_ne),
    .zero_mem(ex_mem_zero), .halt, .pc_src, .enable_pc, .enable_if_id, .enable_id_ex,
    .enable_ex_mem, .enable_mem_wb, .flush_if_id, .flush_id_ex, .flush_ex_mem
  );

  always_ff @(posedge CLK) begin
    if (reset) begin
      mem_wb_wen  <= 1'b0;
      mem_wb_halt <= 1'b0;
    end else if (enable_mem_wb) begin
      mem_wb_wen        <= ex_mem_wen;
      mem_wb_halt       <= ex_mem_halt;
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      mem_wb_dest       <= ex_mem_dest;
      mem_wb_result     <= ex_mem_result;
      mem_wb_load       <= dmem_done ? dload_hold : dmemload;
    end
  end

  // writeback
  assign wdat = (mem_wb_mem_to_reg == SEL_DLOAD) ? mem_wb_load : mem_wb_result;

  // halt in MEM/WB freezes its own stage too so it holds until the next reset
  assign halt = mem_wb_halt;

endmodule

`default_nettype wire

//--- dv/memory_model.sv
// memory model for both datapath ports with optional wait states and a store log the testbench checks
`default_nettype none

module memory_model
  import cpu_types_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t imemaddr,
  input  logic  imemren,
  output word_t imemload,
  output logic  ihit,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  input  logic  dmemren,
  input  logic  dmemwen,
  output word_t dmemload,
  output logic  dhit
);
  timeunit 1ns;
  timeprecision 1ps;

  word_t imem [256];
  word_t dmem [256];
  word_t log_addr [$];
  word_t log_data [$];
  logic  waits_on;
  int    seed;
  int    i_cnt;
  int    d_cnt;
  logic  i_busy;
  logic  d_busy;
  logic  in_reset;

  initial begin
    seed     = 32'ha2e2_7544;
    waits_on = 1'b0;
    i_busy   = 1'b0;
    d_busy   = 1'b0;
    i_cnt    = 0;
    d_cnt    = 0;
    ihit     = 1'b0;
    dhit     = 1'b0;
    imemload = '0;
    dmemload = '0;
  end

  // 0 to 3 wait cycles per access and none in wait-free mode
  function automatic int wait_count();
    if (!waits_on) begin
      return 0;
    end
    return $random(seed) & 32'h3;
  endfunction

  // unused code words decode as halt and data words carry their own address
  task automatic clear_all(input logic use_waits);
    for (int i = 0; i < 256; i++) begin
      imem[i] = {HALT, 26'(i)};
      dmem[i] = 32'hdada_0000 | word_t'(i << 2);
    end
    log_addr.delete();
    log_data.delete();
    waits_on = use_waits;
  endtask

  always @(posedge clk) begin
    // reset as the DUT sees it at this edge
    in_reset = reset;
    #2;
    if (in_reset) begin
      ihit   = 1'b0;
      dhit   = 1'b0;
      i_busy = 1'b0;
      d_busy = 1'b0;
    end else begin
      if (!imemren) begin
        i_busy = 1'b0;
        ihit   = 1'b0;
      end else begin
        // a new access starts after every hit
        if (!i_busy) begin
          i_busy = 1'b1;
          i_cnt  = wait_count();
        end else if (i_cnt != 0) begin
          i_cnt = i_cnt - 1;
        end
        ihit = (i_cnt == 0);
        if (ihit) begin
          i_busy = 1'b0;
        end
      end

      if (!(dmemren || dmemwen)) begin
        d_busy = 1'b0;
        dhit   = 1'b0;
      end else begin
        if (!d_busy) begin
          d_busy = 1'b1;
          d_cnt  = wait_count();
        end else if (d_cnt != 0) begin
          d_cnt = d_cnt - 1;
        end
        dhit = (d_cnt == 0);
        if (dhit) begin
          d_busy = 1'b0;
          if (dmemwen) begin
            dmem[dmemaddr[9:2]] = dmemstore;
            log_addr.push_back(dmemaddr);
            log_data.push_back(dmemstore);
          end
        end
      end
    end
    imemload = imem[imemaddr[9:2]];
    dmemload = dmem[dmemaddr[9:2]];
  end

endmodule

`default_nettype wire

//--- dv/datapath_tb.sv
// top testbench, runs directed programs through the pipeline and checks the store log
`default_nettype none

module datapath_tb
  import cpu_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic  clk;
  logic  reset;
  word_t imemaddr, imemload, dmemaddr, dmemstore, dmemload;
  logic  imemren, ihit, dmemren, dmemwen, dhit, halt;
  word_t exp_addr [$];
  word_t exp_data [$];

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
  end

  always #20 clk = ~clk;

  datapath dut0 (
    .CLK(clk), .reset, .imemaddr, .imemren, .imemload, .ihit,
    .dmemaddr, .dmemstore, .dmemren, .dmemwen, .dmemload, .dhit, .halt
  );

  memory_model mem0 (
    .clk, .reset, .imemaddr, .imemren, .imemload, .ihit,
    .dmemaddr, .dmemstore, .dmemren, .dmemwen, .dmemload, .dhit
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("MISMATCH %s: expected %h got %h", name, exp, got));
    end
  endtask

  // MIPS instruction formats
  function automatic word_t rtype_word(input funct_t f, input regbits_t rs,
                                       input regbits_t rt, input regbits_t rd,
                                       input logic [4:0] sh);
    return {RTYPE, rs, rt, rd, sh, f};
  endfunction

  function automatic word_t itype_word(input opcode_t op, input regbits_t rs,
                                       input regbits_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype_word(input opcode_t op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic prepare_memory(input logic use_waits);
    mem0.clear_all(use_waits);
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic place_instr(input int idx, input word_t w);
    mem0.imem[idx] = w;
  endtask

  task automatic preload_data(input word_t addr, input word_t w);
    mem0.dmem[addr[9:2]] = w;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_word("imemaddr after reset", imemaddr, PC_INIT);
    check_word("imemren after reset", 32'(imemren), 32'd1);
    check_word("dmemren after reset", 32'(dmemren), 32'd0);
    check_word("dmemwen after reset", 32'(dmemwen), 32'd0);
    check_word("halt after reset", 32'(halt), 32'd0);
    @(posedge clk);
    #2 reset = 1'b0;
  endtask

  task automatic wait_for_halt(input string test);
    int cycles;
    cycles = 0;
    while (!halt && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    assert (halt) else begin
      stop_on_error($sformatf("%s: program never halted within %0d cycles", test, cycles));
    end
  endtask

  task automatic compare_store_log(input string test);
    assert (mem0.log_addr.size() == exp_addr.size()) else begin
      stop_on_error($sformatf("%s: %0d stores logged where %0d were expected",
                              test, mem0.log_addr.size(), exp_addr.size()));
    end
    foreach (exp_addr[i]) begin
      check_word($sformatf("%s store %0d address", test, i), mem0.log_addr[i], exp_addr[i]);
      check_word($sformatf("%s store %0d data", test, i), mem0.log_data[i], exp_data[i]);
    end
  endtask

  task automatic run_program(input string test);
    apply_reset();
    wait_for_halt(test);
    compare_store_log(test);
  endtask

  // back to back dependencies through MEM and WB forwarding
  task automatic alu_dependency_test(input logic use_waits);
    word_t r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11;
    prepare_memory(use_waits);
    place_instr(0, itype_word(ORI, 5'd0, 5'd1, 16'h0005));
    place_instr(1, itype_word(ADDIU, 5'd1, 5'd2, 16'h0007));
    place_instr(2, rtype_word(ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    place_instr(3, itype_word(SW, 5'd0, 5'd3, 16'h0000));
    place_instr(4, rtype_word(SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
    place_instr(5, itype_word(SW, 5'd0, 5'd4, 16'h0004));
    place_instr(6, itype_word(LUI, 5'd0, 5'd5, 16'h1234));
    place_instr(7, rtype_word(OR, 5'd5, 5'd4, 5'd6, 5'd0));
    place_instr(8, itype_word(SW, 5'd0, 5'd6, 16'h0008));
    place_instr(9, rtype_word(AND, 5'd6, 5'd2, 5'd7, 5'd0));
    place_instr(10, itype_word(SW, 5'd0, 5'd7, 16'h000c));
    place_instr(11, rtype_word(SLT, 5'd4, 5'd3, 5'd8, 5'd0));
    place_instr(12, rtype_word(SLL, 5'd0, 5'd8, 5'd9, 5'd4));
    place_instr(13, itype_word(SW, 5'd0, 5'd9, 16'h0010));
    place_instr(14, itype_word(ADDIU, 5'd0, 5'd10, 16'hfffd));
    place_instr(15, rtype_word(SLT, 5'd10, 5'd1, 5'd11, 5'd0));
    place_instr(16, itype_word(SW, 5'd0, 5'd11, 16'h0014));
    place_instr(17, jtype_word(HALT, 26'd0));
    r1  = 32'd5;
    r2  = r1 + 32'd7;
    r3  = r1 + r2;
    r4  = r3 - r1;
    r5  = 32'h1234_0000;
    r6  = r5 | r4;
    r7  = r6 & r2;
    r8  = ($signed(r4) < $signed(r3)) ? 32'd1 : 32'd0;
    r9  = r8 << 4;
    // addiu sign-extends, slt compares signed
    r10 = 32'hffff_fffd;
    r11 = ($signed(r10) < $signed(r1)) ? 32'd1 : 32'd0;
    expect_store(32'h00, r3);
    expect_store(32'h04, r4);
    expect_store(32'h08, r6);
    expect_store(32'h0c, r7);
    expect_store(32'h10, r9);
    expect_store(32'h14, r11);
    run_program("alu dependency");
  endtask

  task automatic load_use_test(input logic use_waits);
    word_t r1, r2, r3, r4;
    prepare_memory(use_waits);
    preload_data(32'h40, 32'h0000_1111);
    preload_data(32'h44, 32'hcafe_0000);
    place_instr(0, itype_word(LW, 5'd0, 5'd1, 16'h0040));
    place_instr(1, itype_word(ADDIU, 5'd1, 5'd2, 16'h0001));
    place_instr(2, itype_word(SW, 5'd0, 5'd2, 16'h0080));
    place_instr(3, itype_word(LW, 5'd0, 5'd3, 16'h0044));
    place_instr(4, rtype_word(SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
    place_instr(5, itype_word(SW, 5'd0, 5'd4, 16'h0084));
    place_instr(6, itype_word(LW, 5'd0, 5'd5, 16'h0080));
    place_instr(7, itype_word(SW, 5'd0, 5'd5, 16'h0088));
    place_instr(8, jtype_word(HALT, 26'd0));
    r1 = 32'h0000_1111;
    r2 = r1 + 32'd1;
    r3 = 32'hcafe_0000;
    r4 = r3 - r1;
    expect_store(32'h80, r2);
    expect_store(32'h84, r4);
    // reload of the word stored at 0x80
    expect_store(32'h88, r2);
    run_program("load use");
  endtask

  // taken and not taken branches, wrong path stores must be flushed
  task automatic branch_test(input logic use_waits);
    prepare_memory(use_waits);
    place_instr(0, itype_word(ORI, 5'd0, 5'd1, 16'h0003));
    place_instr(1, itype_word(ORI, 5'd0, 5'd2, 16'h0003));
    place_instr(2, itype_word(ORI, 5'd0, 5'd3, 16'h0009));
    place_instr(3, itype_word(BEQ, 5'd1, 5'd2, 16'd2));
    place_instr(4, itype_word(SW, 5'd0, 5'd1, 16'h0100));
    place_instr(5, itype_word(SW, 5'd0, 5'd1, 16'h0104));
    place_instr(6, itype_word(BNE, 5'd1, 5'd3, 16'd1));
    place_instr(7, itype_word(SW, 5'd0, 5'd1, 16'h0108));
    place_instr(8, itype_word(BEQ, 5'd1, 5'd3, 16'd1));
    place_instr(9, itype_word(SW, 5'd0, 5'd3, 16'h010c));
    place_instr(10, itype_word(BNE, 5'd1, 5'd2, 16'd1));
    place_instr(11, itype_word(SW, 5'd0, 5'd2, 16'h0110));
    place_instr(12, jtype_word(HALT, 26'd0));
    expect_store(32'h10c, 32'd9);
    expect_store(32'h110, 32'd3);
    run_program("branch");
  endtask

  task automatic jump_link_test(input logic use_waits);
    word_t link;
    prepare_memory(use_waits);
    place_instr(0, itype_word(ORI, 5'd0, 5'd1, 16'h0011));
    place_instr(1, jtype_word(J, 26'd4));
    place_instr(2, itype_word(SW, 5'd0, 5'd1, 16'h0200));
    place_instr(3, itype_word(SW, 5'd0, 5'd1, 16'h0204));
    place_instr(4, itype_word(SW, 5'd0, 5'd1, 16'h0208));
    place_instr(5, jtype_word(JAL, 26'd10));
    place_instr(6, itype_word(SW, 5'd0, 5'd1, 16'h020c));
    place_instr(7, jtype_word(HALT, 26'd0));
    place_instr(10, itype_word(SW, 5'd0, LINK_REG, 16'h0210));
    place_instr(11, rtype_word(JR, LINK_REG, 5'd0, 5'd0, 5'd0));
    // jal sits at byte address 20, link is the word after it
    link = 32'd20 + 32'd4;
    expect_store(32'h208, 32'h11);
    expect_store(32'h210, link);
    expect_store(32'h20c, 32'h11);
    run_program("jump and link");
  endtask

  task automatic halt_hold_test();
    int stores;
    prepare_memory(1'b0);
    place_instr(0, itype_word(ORI, 5'd0, 5'd1, 16'h0042));
    place_instr(1, itype_word(SW, 5'd0, 5'd1, 16'h0030));
    place_instr(2, jtype_word(HALT, 26'd0));
    place_instr(3, itype_word(SW, 5'd0, 5'd1, 16'h0034));
    expect_store(32'h30, 32'h42);
    run_program("halt hold");
    stores = mem0.log_addr.size();
    repeat (20) begin
      @(negedge clk);
      check_word("halt while halted", 32'(halt), 32'd1);
      check_word("store count while halted", word_t'(mem0.log_addr.size()), word_t'(stores));
    end
    // reset must bring halt back down
    apply_reset();
  endtask

  initial begin
    alu_dependency_test(1'b0);
    load_use_test(1'b0);
    branch_test(1'b0);
    jump_link_test(1'b0);
    // same programs with random wait states on both ports
    alu_dependency_test(1'b1);
    load_use_test(1'b1);
    branch_test(1'b1);
    jump_link_test(1'b1);
    halt_hold_test();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/cpu_types_pkg.sv
verilog/data_path_muxs_pkg.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/forward_unit.sv
verilog/datapath.sv
dv/memory_model.sv
dv/datapath_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the pipeline testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module datapath_tb -Mdir obj_dir -o datapath_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/datapath_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
